//--- common/socPkg.sv
package socPkg;

    // Data path and register file sizes
    localparam int wordWidth = 32;
    localparam int regIndexWidth = 4;
    localparam int immWidth = 20;

    // Address map
    // Bit 31 clear selects RAM at a word address
    localparam int peripheralBit = 31;
    localparam logic [wordWidth-1:0] ledAddr = 32'h8000_0000;
    // Bits 15..8 carry x and bits 7..0 carry y inside this window
    localparam logic [wordWidth-1:0] pixelBase = 32'hC000_0000;

    // Opcode sits in instruction bits 31..28
    typedef enum logic [3:0] {
        LOADI = 4'd0,
        ADD   = 4'd1,
        SUB   = 4'd2,
        AND   = 4'd3,
        OR    = 4'd4,
        ADDI  = 4'd5,
        LOAD  = 4'd6,
        STORE = 4'd7,
        BNZ   = 4'd8,
        HALT  = 4'd9
    } opcode_t;

    typedef struct packed {
        opcode_t                  opcode;
        logic [regIndexWidth-1:0] rd;
        logic [regIndexWidth-1:0] rs;
        logic [wordWidth-1:0]     imm;
        logic                     writesReg;
        logic                     isLoad;
        logic                     isStore;
        logic                     isBranch;
        logic                     isHalt;
    } ctrl_t;

endpackage

//--- common/memBus.sv
`timescale 1ns/10ps

// One word-wide memory port
// Read data follows a read strobe by one cycle, writes land on the strobe edge
interface memBus;
    import socPkg::*;

    logic [wordWidth-1:0] addr;
    logic [wordWidth-1:0] wdata;
    logic                 write;
    logic                 read;
    logic [wordWidth-1:0] rdata;

    modport master (
        output addr, wdata, write, read,
        input  rdata
    );

    modport slave (
        input  addr, wdata, write, read,
        output rdata
    );

endinterface

//--- cpu/instrDecode.sv
`timescale 1ns/10ps

module instrDecode (
    input  logic                         clk_25mhz,
    input  logic                         reset,
    input  logic [socPkg::wordWidth-1:0] instr,
    input  logic                         decodeEn,
    output socPkg::ctrl_t                ctrl
);
    import socPkg::*;

    ctrl_t decoded;

    always_comb begin
        decoded = '0;
        decoded.rd = instr[27:24];
        decoded.rs = instr[23:20];
        // Sign-extend the low immediate field
        decoded.imm = {{(wordWidth - immWidth){instr[immWidth-1]}}, instr[immWidth-1:0]};

        case (instr[31:28])
            LOADI, ADD, SUB, AND, OR, ADDI: begin
                decoded.opcode = opcode_t'(instr[31:28]);
                decoded.writesReg = 1'b1;
            end
            LOAD: begin
                decoded.opcode = LOAD;
                decoded.writesReg = 1'b1;
                decoded.isLoad = 1'b1;
            end
            STORE: begin
                decoded.opcode = STORE;
                decoded.isStore = 1'b1;
            end
            BNZ: begin
                decoded.opcode = BNZ;
                decoded.isBranch = 1'b1;
            end
            // HALT and every unused encoding stop the core
            default: begin
                decoded.opcode = HALT;
                decoded.isHalt = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            ctrl <= '0;
        end else if (decodeEn) begin
            ctrl <= decoded;
        end
    end

endmodule

//--- cpu/execUnit.sv
`timescale 1ns/10ps

module execUnit (
    input  logic                         clk_25mhz,
    input  logic                         reset,
    input  socPkg::ctrl_t                ctrl,
    input  logic [socPkg::wordWidth-1:0] rdValue,
    input  logic [socPkg::wordWidth-1:0] rsValue,
    input  logic                         execEn,
    output logic [socPkg::wordWidth-1:0] aluResult,
    output logic [socPkg::wordWidth-1:0] memAddr,
    output logic                         branchTaken
);
    import socPkg::*;

    logic [wordWidth-1:0] aluNext;
    logic [wordWidth-1:0] addrNext;
    logic                 takenNext;

    // Effective address for LOAD and STORE
    assign addrNext = rsValue + ctrl.imm;

    // BNZ tests register rd
    assign takenNext = ctrl.isBranch && (rdValue != '0);

    // Register ops update rd in place, ADDI takes rs as its source
    always_comb begin
        case (ctrl.opcode)
            LOADI:   aluNext = ctrl.imm;
            ADD:     aluNext = rdValue + rsValue;
            SUB:     aluNext = rdValue - rsValue;
            AND:     aluNext = rdValue & rsValue;
            OR:      aluNext = rdValue | rsValue;
            ADDI:    aluNext = rsValue + ctrl.imm;
            default: aluNext = addrNext;
        endcase
    end

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            branchTaken <= 1'b0;
        end else if (execEn) begin
            branchTaken <= takenNext;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (execEn) begin
            aluResult <= aluNext;
            memAddr <= addrNext;
        end
    end

endmodule

//--- cpu/resultStage.sv
`timescale 1ns/10ps

module resultStage (
    input  socPkg::ctrl_t                ctrl,
    input  logic [socPkg::wordWidth-1:0] aluResult,
    input  logic [socPkg::wordWidth-1:0] loadData,
    input  logic [socPkg::wordWidth-1:0] pc,
    input  logic                         branchTaken,
    output logic                         regWrite,
    output logic [socPkg::wordWidth-1:0] regData,
    output logic [socPkg::wordWidth-1:0] nextPc
);
    import socPkg::*;

    // Register 0 is hard zero, so it never takes a write
    assign regWrite = ctrl.writesReg && (ctrl.rd != '0);

    assign regData = ctrl.isLoad ? loadData : aluResult;

    // Branch offset is relative to the branch itself
    assign nextPc = branchTaken ? pc + ctrl.imm : pc + 1'b1;

endmodule

//--- cpu/cpuCore.sv
`timescale 1ns/10ps

module cpuCore (
    input  logic  clk_25mhz,
    input  logic  reset,
    input  logic  cpuRun,
    memBus.master bus,
    output logic  halted
);
    import socPkg::*;

    typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, RESULT, STOP} state_t;

    state_t               state;
    logic                 hold;
    logic [wordWidth-1:0] pc;
    logic [wordWidth-1:0] regs [2**regIndexWidth];
    logic [wordWidth-1:0] rdValue;
    logic [wordWidth-1:0] rsValue;
    logic [wordWidth-1:0] aluResult;
    logic [wordWidth-1:0] memAddr;
    logic [wordWidth-1:0] regData;
    logic [wordWidth-1:0] nextPc;
    logic                 branchTaken;
    logic                 regWrite;
    ctrl_t                ctrl;

    // Loader keeps the core parked at address 0
    assign hold = reset || !cpuRun;

    assign rdValue = (ctrl.rd == '0) ? '0 : regs[ctrl.rd];
    assign rsValue = (ctrl.rs == '0) ? '0 : regs[ctrl.rs];

    instrDecode instrDecode_inst (
        .clk_25mhz (clk_25mhz),
        .reset     (reset),
        .instr     (bus.rdata),
        .decodeEn  (state == DECODE),
        .ctrl      (ctrl)
    );

    execUnit execUnit_inst (
        .clk_25mhz   (clk_25mhz),
        .reset       (reset),
        .ctrl        (ctrl),
        .rdValue     (rdValue),
        .rsValue     (rsValue),
        .execEn      (state == EXEC),
        .aluResult   (aluResult),
        .memAddr     (memAddr),
        .branchTaken (branchTaken)
    );

    resultStage resultStage_inst (
        .ctrl        (ctrl),
        .aluResult   (aluResult),
        .loadData    (bus.rdata),
        .pc          (pc),
        .branchTaken (branchTaken),
        .regWrite    (regWrite),
        .regData     (regData),
        .nextPc      (nextPc)
    );

    // Instruction fetch in FETCH, data access in MEM
    assign bus.addr = (state == MEM) ? memAddr : pc;
    assign bus.wdata = rdValue;
    assign bus.read = (state == FETCH && cpuRun) || (state == MEM && ctrl.isLoad);
    assign bus.write = (state == MEM) && ctrl.isStore;

    always_ff @(posedge clk_25mhz) begin
        if (hold) begin
            state <= FETCH;
            pc <= '0;
            halted <= 1'b0;
        end else begin
            case (state)
                FETCH:  state <= DECODE;
                DECODE: state <= EXEC;
                EXEC: begin
                    if (ctrl.isHalt) begin
                        state <= STOP;
                        halted <= 1'b1;
                    end else if (ctrl.isLoad || ctrl.isStore) begin
                        state <= MEM;
                    end else begin
                        state <= RESULT;
                    end
                end
                MEM:    state <= RESULT;
                RESULT: begin
                    state <= FETCH;
                    pc <= nextPc;
                end
                default: state <= STOP;
            endcase
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (state == RESULT && regWrite) begin
            regs[ctrl.rd] <= regData;
        end
    end

    a_readWriteExclusive: assert property (@(posedge clk_25mhz) disable iff (reset)
        !(bus.read && bus.write));

    a_quietWhenHalted: assert property (@(posedge clk_25mhz) disable iff (reset)
        halted |-> !bus.read && !bus.write);

endmodule

//--- logic/wordRam.sv
`timescale 1ns/10ps

module wordRam #(
    parameter int ramWords = 1024
) (
    input logic  clk_25mhz,
    memBus.slave bus
);
    import socPkg::*;

    localparam int addrBits = $clog2(ramWords);

    logic [wordWidth-1:0] mem [ramWords];
    logic [addrBits-1:0]  index;

    assign index = bus.addr[addrBits-1:0];

    always_ff @(posedge clk_25mhz) begin
        if (bus.write) begin
            mem[index] <= bus.wdata;
        end
    end

    // Read data holds until the next read strobe
    always_ff @(posedge clk_25mhz) begin
        if (bus.read) begin
            bus.rdata <= mem[index];
        end
    end

endmodule

//--- logic/busDecode.sv
`timescale 1ns/10ps

module busDecode #(
    parameter int ramWords = 1024
) (
    input  logic       clk_25mhz,
    input  logic       reset,
    input  logic       cpuRun,
    memBus.slave       loaderBus,
    memBus.slave       cpuBus,
    memBus.master      ramBus,
    output logic [7:0] led,
    output logic       pixelWrite,
    output logic [7:0] pixelX,
    output logic [7:0] pixelY,
    output logic [7:0] pixelColor
);
    import socPkg::*;

    logic [wordWidth-1:0] selAddr;
    logic [wordWidth-1:0] selWdata;
    logic                 selWrite;
    logic                 selRead;
    logic                 ramSpace;
    logic                 ledHit;
    logic                 pixelHit;

    // Loader owns the bus until the core is released
    assign selAddr = cpuRun ? cpuBus.addr : loaderBus.addr;
    assign selWdata = cpuRun ? cpuBus.wdata : loaderBus.wdata;
    assign selWrite = cpuRun ? cpuBus.write : loaderBus.write;
    assign selRead = cpuRun ? cpuBus.read : loaderBus.read;

    assign ramSpace = !selAddr[peripheralBit];
    assign ledHit = selWrite && (selAddr[31:30] == ledAddr[31:30]);
    assign pixelHit = selWrite && (selAddr[31:30] == pixelBase[31:30]);

    assign ramBus.addr = selAddr & (ramWords - 1);
    assign ramBus.wdata = selWdata;
    assign ramBus.write = selWrite && ramSpace;
    assign ramBus.read = selRead && ramSpace;

    assign loaderBus.rdata = ramBus.rdata;
    assign cpuBus.rdata = ramBus.rdata;

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            led <= '0;
            pixelWrite <= 1'b0;
        end else begin
            pixelWrite <= pixelHit;
            if (ledHit) begin
                led <= selWdata[7:0];
            end
        end
    end

    // Pixel fields ride along with the strobe
    always_ff @(posedge clk_25mhz) begin
        if (pixelHit) begin
            pixelX <= selAddr[15:8];
            pixelY <= selAddr[7:0];
            pixelColor <= selWdata[7:0];
        end
    end

    a_ramInRange: assert property (@(posedge clk_25mhz) disable iff (reset)
        ramSpace && (selRead || selWrite) |-> selAddr < ramWords);

endmodule

//--- logic/bootLoader.sv
`timescale 1ns/10ps

module bootLoader (
    input  logic       clk_25mhz,
    input  logic       reset,
    input  logic [7:0] loadByte,
    input  logic       loadStrobe,
    memBus.master      bus,
    output logic       cpuRun
);
    import socPkg::*;

    logic [wordWidth-1:0] shiftReg;
    logic [wordWidth-1:0] nextWord;
    logic [wordWidth-1:0] wordsLeft;
    logic [wordWidth-1:0] writeAddr;
    logic [1:0]           byteCount;
    logic                 haveCount;
    logic                 writePending;
    logic                 acceptByte;

    // Little-endian assembly, first byte lands lowest
    assign nextWord = {loadByte, shiftReg[wordWidth-1:8]};

    // Bytes stop counting once the final word is on its way
    assign acceptByte = loadStrobe && !cpuRun && !(writePending && wordsLeft == 1);

    assign bus.addr = writeAddr;
    assign bus.wdata = shiftReg;
    assign bus.write = writePending;
    assign bus.read = 1'b0;

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            byteCount <= '0;
            haveCount <= 1'b0;
            writePending <= 1'b0;
            wordsLeft <= '0;
            writeAddr <= '0;
            cpuRun <= 1'b0;
        end else begin
            if (writePending) begin
                writePending <= 1'b0;
                writeAddr <= writeAddr + 1'b1;
                wordsLeft <= wordsLeft - 1'b1;
                if (wordsLeft == 1) begin
                    cpuRun <= 1'b1;
                end
            end
            if (acceptByte) begin
                byteCount <= byteCount + 1'b1;
                if (byteCount == 2'd3) begin
                    if (!haveCount) begin
                        haveCount <= 1'b1;
                        wordsLeft <= nextWord;
                        // Empty image starts the core right away
                        if (nextWord == '0) begin
                            cpuRun <= 1'b1;
                        end
                    end else begin
                        writePending <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (acceptByte) begin
            shiftReg <= nextWord;
        end
    end

    a_noWriteAfterRun: assert property (@(posedge clk_25mhz) disable iff (reset)
        cpuRun |-> !bus.write);

endmodule

//--- logic/socTop.sv
`timescale 1ns/10ps

module socTop #(
    parameter int ramWords = 1024
) (
    input  logic       clk_25mhz,
    input  logic       reset,
    input  logic [7:0] loadByte,
    input  logic       loadStrobe,
    output logic       loading,
    output logic       halted,
    output logic [7:0] led,
    output logic       pixelWrite,
    output logic [7:0] pixelX,
    output logic [7:0] pixelY,
    output logic [7:0] pixelColor
);

    logic cpuRun;

    memBus loaderBus ();
    memBus cpuBus ();
    memBus ramBus ();

    assign loading = !cpuRun;

    bootLoader bootLoader_inst (
        .clk_25mhz  (clk_25mhz),
        .reset      (reset),
        .loadByte   (loadByte),
        .loadStrobe (loadStrobe),
        .bus        (loaderBus.master),
        .cpuRun     (cpuRun)
    );

    cpuCore cpuCore_inst (
        .clk_25mhz (clk_25mhz),
        .reset     (reset),
        .cpuRun    (cpuRun),
        .bus       (cpuBus.master),
        .halted    (halted)
    );

    busDecode #(
        .ramWords (ramWords)
    ) busDecode_inst (
        .clk_25mhz  (clk_25mhz),
        .reset      (reset),
        .cpuRun     (cpuRun),
        .loaderBus  (loaderBus.slave),
        .cpuBus     (cpuBus.slave),
        .ramBus     (ramBus.master),
        .led        (led),
        .pixelWrite (pixelWrite),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .pixelColor (pixelColor)
    );

    wordRam #(
        .ramWords (ramWords)
    ) wordRam_inst (
        .clk_25mhz (clk_25mhz),
        .bus       (ramBus.slave)
    );

endmodule

//--- verif/socTop_tb.sv
`timescale 1ns/10ps

module socTop_tb;
    import socPkg::*;

    // Each program loads and runs in well under a thousand cycles
    localparam int cycleLimit = 20000;

    logic       clk_25mhz;
    logic       reset;
    logic [7:0] loadByte;
    logic       loadStrobe;
    logic       loading;
    logic       halted;
    logic [7:0] led;
    logic       pixelWrite;
    logic [7:0] pixelX;
    logic [7:0] pixelY;
    logic [7:0] pixelColor;

    logic [31:0] prog [256];
    int          progLen;
    logic [7:0]  expLed [64];
    logic [7:0]  expPixX [64];
    logic [7:0]  expPixY [64];
    logic [7:0]  expPixC [64];
    int          expLedCount;
    int          expPixCount;
    int          ledIdx;
    int          pixIdx;
    logic [7:0]  ledPrev;
    logic        haltSeen;
    int          valueErrors;
    int          otherErrors;
    int          cycles;
    int          wordsDeclared;
    int          wordsSent;

    socTop socTop_inst (
        .clk_25mhz  (clk_25mhz),
        .reset      (reset),
        .loadByte   (loadByte),
        .loadStrobe (loadStrobe),
        .loading    (loading),
        .halted     (halted),
        .led        (led),
        .pixelWrite (pixelWrite),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .pixelColor (pixelColor)
    );

    initial begin
        clk_25mhz = 1'b0;
        forever #20 clk_25mhz = ~clk_25mhz;
    end

    // Progress counters for the output checks
    always @(posedge clk_25mhz) begin
        cycles <= cycles + 1;
        if (reset) begin
            ledIdx <= 0;
            pixIdx <= 0;
            ledPrev <= '0;
            haltSeen <= 1'b0;
        end else begin
            if (pixelWrite) begin
                pixIdx <= pixIdx + 1;
            end
            if (led != ledPrev) begin
                ledIdx <= ledIdx + 1;
            end
            ledPrev <= led;
            if (halted) begin
                haltSeen <= 1'b1;
            end
        end
    end

    always @(posedge clk_25mhz) begin
        if (cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    a_loadingHeld: assert property (@(negedge clk_25mhz) disable iff (reset)
        wordsSent < wordsDeclared |-> loading)
        else begin
            otherErrors++;
            $display("Loading fell before all %0d words arrived", wordsDeclared);
        end

    a_pixelCount: assert property (@(negedge clk_25mhz) disable iff (reset)
        pixelWrite |-> pixIdx < expPixCount)
        else begin
            otherErrors++;
            $display("Unexpected pixel strobe number %0d at %0t", pixIdx + 1, $time);
        end

    a_pixelX: assert property (@(negedge clk_25mhz) disable iff (reset)
        pixelWrite |-> pixelX == expPixX[pixIdx[5:0]])
        else begin
            valueErrors++;
            $display("ERROR t=%0t pixelX got %h expected %h", $time, pixelX,
                expPixX[pixIdx[5:0]]);
        end

    a_pixelY: assert property (@(negedge clk_25mhz) disable iff (reset)
        pixelWrite |-> pixelY == expPixY[pixIdx[5:0]])
        else begin
            valueErrors++;
            $display("ERROR t=%0t pixelY got %h expected %h", $time, pixelY,
                expPixY[pixIdx[5:0]]);
        end

    a_pixelColor: assert property (@(negedge clk_25mhz) disable iff (reset)
        pixelWrite |-> pixelColor == expPixC[pixIdx[5:0]])
        else begin
            valueErrors++;
            $display("ERROR t=%0t pixelColor got %h expected %h", $time, pixelColor,
                expPixC[pixIdx[5:0]]);
        end

    a_ledValue: assert property (@(negedge clk_25mhz) disable iff (reset)
        led != ledPrev |-> ledIdx < expLedCount && led == expLed[ledIdx[5:0]])
        else begin
            valueErrors++;
            $display("ERROR t=%0t led got %h expected %h", $time, led, expLed[ledIdx[5:0]]);
        end

    a_haltSticky: assert property (@(negedge clk_25mhz) disable iff (reset)
        haltSeen |-> halted)
        else begin
            otherErrors++;
            $display("Halted dropped at %0t", $time);
        end

    a_quietAfterHalt: assert property (@(negedge clk_25mhz) disable iff (reset)
        haltSeen |-> !pixelWrite && led == ledPrev)
        else begin
            otherErrors++;
            $display("Output activity after halt at %0t", $time);
        end

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        assert (got == expected)
        else begin
            valueErrors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic emit(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs,
                        input logic [19:0] imm);
        prog[progLen] = {op, rd, rs, imm};
        progLen++;
    endtask

    // r1 ends at the LED address and r3 at the pixel window base
    task automatic buildPrologue();
        progLen = 0;
        emit(LOADI, 4'd1, 4'd0, 20'd1);
        repeat (30) emit(ADD, 4'd1, 4'd1, 20'd0);
        emit(ADDI, 4'd3, 4'd1, 20'd0);
        emit(ADD, 4'd1, 4'd1, 20'd0);
        emit(OR, 4'd3, 4'd1, 20'd0);
    endtask

    // ISA reference model run over the assembled program
    task automatic runModel();
        logic [31:0] r [16];
        logic [31:0] mem [1024];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] imm;
        logic [31:0] a;
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [7:0]  lastLed;
        foreach (mem[i]) mem[i] = '0;
        foreach (r[i]) r[i] = '0;
        for (int i = 0; i < progLen; i++) mem[i] = prog[i];
        pc = '0;
        lastLed = '0;
        expLedCount = 0;
        expPixCount = 0;
        for (int steps = 0; steps < 5000; steps++) begin
            ins = mem[pc[9:0]];
            op = ins[31:28];
            rd = ins[27:24];
            rs = ins[23:20];
            imm = {{12{ins[19]}}, ins[19:0]};
            a = r[rs] + imm;
            if (op >= HALT) break;
            case (op)
                LOADI: r[rd] = imm;
                ADD:   r[rd] = r[rd] + r[rs];
                SUB:   r[rd] = r[rd] - r[rs];
                AND:   r[rd] = r[rd] & r[rs];
                OR:    r[rd] = r[rd] | r[rs];
                ADDI:  r[rd] = r[rs] + imm;
                LOAD:  r[rd] = mem[a[9:0]];
                STORE: begin
                    if (!a[31]) begin
                        mem[a[9:0]] = r[rd];
                    end else if (!a[30]) begin
                        // Only a change of value is visible on the pins
                        if (r[rd][7:0] != lastLed) begin
                            expLed[expLedCount[5:0]] = r[rd][7:0];
                            expLedCount++;
                        end
                        lastLed = r[rd][7:0];
                    end else begin
                        expPixX[expPixCount[5:0]] = a[15:8];
                        expPixY[expPixCount[5:0]] = a[7:0];
                        expPixC[expPixCount[5:0]] = r[rd][7:0];
                        expPixCount++;
                    end
                end
                default: ;
            endcase
            r[0] = '0;
            pc = (op == BNZ && r[rd] != '0) ? pc + imm : pc + 1;
        end
    endtask

    task automatic applyReset();
        @(negedge clk_25mhz);
        reset = 1'b1;
        loadStrobe = 1'b0;
        wordsDeclared = 0;
        wordsSent = 0;
        repeat (8) @(negedge clk_25mhz);
        reset = 1'b0;
    endtask

    task automatic sendWord(input logic [31:0] w);
        for (int k = 0; k < 4; k++) begin
            @(negedge clk_25mhz);
            loadByte = w[8*k +: 8];
            loadStrobe = 1'b1;
        end
    endtask

    task automatic runProgram();
        runModel();
        applyReset();
        compareValue("loading", 32'(loading), 32'd1);
        wordsDeclared = progLen;
        sendWord(32'(progLen));
        for (int i = 0; i < progLen; i++) begin
            sendWord(prog[i]);
            wordsSent++;
        end
        @(negedge clk_25mhz);
        loadStrobe = 1'b0;
        // Final word is being written in this cycle
        compareValue("loading", 32'(loading), 32'd1);
        while (loading) @(negedge clk_25mhz);
        while (!halted) @(negedge clk_25mhz);
        repeat (200) @(negedge clk_25mhz);
        compareValue("ledChanges", 32'(ledIdx), 32'(expLedCount));
        compareValue("pixelStrobes", 32'(pixIdx), 32'(expPixCount));
    endtask

    initial begin
        void'($urandom(2));
        reset = 1'b1;
        loadByte = '0;
        loadStrobe = 1'b0;
        cycles = 0;
        valueErrors = 0;
        otherErrors = 0;
        applyReset();

        // Idle state, then an empty image
        compareValue("led", 32'(led), 32'd0);
        compareValue("pixelWrite", 32'(pixelWrite), 32'd0);
        compareValue("halted", 32'(halted), 32'd0);
        compareValue("loading", 32'(loading), 32'd1);
        sendWord(32'd0);
        compareValue("loading", 32'(loading), 32'd1);
        @(negedge clk_25mhz);
        loadStrobe = 1'b0;
        compareValue("loading", 32'(loading), 32'd0);

        // Arithmetic on random operands
        buildPrologue();
        emit(LOADI, 4'd7, 4'd0, 20'($urandom));
        emit(LOADI, 4'd8, 4'd0, 20'($urandom));
        emit(STORE, 4'd7, 4'd1, 20'd0);
        for (int op = ADD; op <= OR; op++) begin
            emit(4'(op), 4'd7, 4'd8, 20'd0);
            emit(STORE, 4'd7, 4'd1, 20'd0);
        end
        emit(ADDI, 4'd7, 4'd8, 20'($urandom));
        emit(STORE, 4'd7, 4'd1, 20'd0);
        emit(HALT, 4'd0, 4'd0, 20'd0);
        runProgram();

        // Store then load back through RAM
        buildPrologue();
        for (int k = 0; k < 4; k++) begin
            emit(LOADI, 4'd7, 4'd0, 20'($urandom));
            emit(STORE, 4'd7, 4'd0, 20'(200 + 3 * k));
        end
        for (int k = 0; k < 4; k++) begin
            emit(LOAD, 4'd9, 4'd0, 20'(200 + 3 * k));
            emit(STORE, 4'd9, 4'd1, 20'd0);
        end
        emit(HALT, 4'd0, 4'd0, 20'd0);
        runProgram();

        // Countdown loop drawing a diagonal
        buildPrologue();
        emit(ADDI, 4'd4, 4'd3, 20'h00A14);
        emit(LOADI, 4'd5, 4'd0, 20'($urandom));
        emit(LOADI, 4'd6, 4'd0, 20'd6);
        emit(STORE, 4'd5, 4'd4, 20'd0);
        emit(ADDI, 4'd4, 4'd4, 20'h00103);
        emit(ADDI, 4'd5, 4'd5, 20'd7);
        emit(ADDI, 4'd6, 4'd6, 20'hFFFFF);
        emit(BNZ, 4'd6, 4'd0, 20'hFFFFC);
        emit(HALT, 4'd0, 4'd0, 20'd0);
        runProgram();

        $display("Finished: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- socTop.f
common/socPkg.sv
common/memBus.sv
cpu/instrDecode.sv
cpu/execUnit.sv
cpu/resultStage.sv
cpu/cpuCore.sv
logic/wordRam.sv
logic/busDecode.sv
logic/bootLoader.sv
logic/socTop.sv
verif/socTop_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timing --top-module socTop_tb -Mdir obj_dir -f socTop.f
	out=$$(./obj_dir/VsocTop_tb); status=$$?; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
